// File: spi_reg_top.f
spi_reg_pkg.sv
spi_bit_counter.sv
spi_shifter.sv
spi_frame_ctrl.sv
reg_bank.sv
spi_reg_top.sv
spi_reg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f spi_reg_top.f --top-module spi_reg_tb -o spi_reg_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/spi_reg_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

// File: spi_reg_tb.sv
// SPI host runs spi_clk at 1/8 of clk; REG_COUNT fixed at 16 here; stimulus seeded $urandom
`default_nettype none

module spi_reg_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int reg_count  = 16;
    localparam int half_clks  = 4;
    localparam int frame_bits = 35;
    localparam int data_first = 19;

    localparam logic [1:0] cmd_rd = 2'd1;
    localparam logic [1:0] cmd_wr = 2'd2;

    // One finished frame waiting for comparison
    typedef struct packed {
        logic        is_read;
        logic [15:0] got;
        logic [15:0] exp;
    } result_t;

    logic clk;
    logic rst;
    logic spi_clk;
    logic spi_csn;
    logic spi_mosi;
    logic spi_miso;

    logic [15:0] ref_regs [reg_count];
    result_t     result_q [$];

    spi_reg_top #(.REG_COUNT(reg_count)) i_spi_reg_top (
        .clk      (clk),
        .rst      (rst),
        .spi_clk  (spi_clk),
        .spi_csn  (spi_csn),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    always #20 clk = ~clk;

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [15:0] expected_read(input logic [1:0] cmd,
                                                  input logic [15:0] addr);
        if (cmd != cmd_rd) begin
            return 16'h0000;
        end
        if (int'(addr) >= reg_count) begin
            return 16'h0000;
        end
        return ref_regs[int'(addr)];
    endfunction

    task automatic model_write(input logic [1:0] cmd, input logic [15:0] addr,
                               input logic [15:0] data);
        if (cmd == cmd_wr && int'(addr) < reg_count) begin
            ref_regs[int'(addr)] = data;
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Compare each finished frame one clk after it is queued
    always @(posedge clk) begin : compare_results
        result_t r;
        while (result_q.size() > 0) begin
            r = result_q.pop_front();
            if (r.is_read) begin
                check_value("spi_miso read word", r.got, r.exp);
            end else begin
                check_value("spi_miso level outside read", r.got, r.exp);
            end
        end
    end

    // ========================================
    // SPI host
    // ========================================
    // Inputs change 1 ns after the clk edge, miso is sampled there too
    task automatic half_period(inout logic miso_any);
        repeat (half_clks) begin
            @(posedge clk);
            #1;
            miso_any = miso_any | spi_miso;
        end
    endtask

    task automatic spi_frame(input logic [1:0] cmd, input logic [15:0] addr,
                             input logic [15:0] data, input int bits,
                             output logic [15:0] rd_word, output logic miso_any);
        logic [frame_bits-1:0] frame;
        frame    = {cmd, addr, 1'b0, data};
        rd_word  = 16'h0000;
        miso_any = 1'b0;
        spi_csn  = 1'b0;
        half_period(miso_any);
        for (int i = 0; i < bits; i++) begin
            spi_mosi = frame[frame_bits-1-i];
            half_period(miso_any);
            // Value seen by the host at the rising edge
            if (i >= data_first) begin
                rd_word[frame_bits-1-i] = spi_miso;
            end
            spi_clk = 1'b1;
            half_period(miso_any);
            spi_clk = 1'b0;
        end
        // Keep chip select low so the last flag reaches the clk domain
        half_period(miso_any);
        half_period(miso_any);
        spi_csn  = 1'b1;
        spi_mosi = 1'b0;
        repeat (4) half_period(miso_any);
    endtask

    task automatic wait_miso_low();
        int cycles;
        cycles = 0;
        while (spi_miso !== 1'b0) begin
            if (cycles == 20) begin
                $display("Checks failed");
                $fatal(1, "spi_miso stayed high after chip select was released");
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    task automatic wait_results_drained();
        int cycles;
        cycles = 0;
        while (result_q.size() != 0) begin
            if (cycles == 20) begin
                $display("Checks failed");
                $fatal(1, "queued frame results were never compared");
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    task automatic run_frame(input logic [1:0] cmd, input logic [15:0] addr,
                             input logic [15:0] data, input int bits);
        logic [15:0] exp;
        logic [15:0] got;
        logic        miso_any;
        exp = expected_read(cmd, addr);
        spi_frame(cmd, addr, data, bits, got, miso_any);
        if (cmd == cmd_rd) begin
            result_q.push_back('{is_read: 1'b1, got: got, exp: exp});
        end else begin
            result_q.push_back('{is_read: 1'b0, got: {15'd0, miso_any}, exp: exp});
        end
        // Cut frames never reach the bank
        if (bits == frame_bits) begin
            model_write(cmd, addr, data);
        end
        wait_miso_low();
    endtask

    task automatic read_all();
        for (int a = 0; a < reg_count; a++) begin
            run_frame(cmd_rd, 16'(a), 16'h0000, frame_bits);
        end
    endtask

    // ========================================
    // Scenarios
    // ========================================
    initial begin
        logic [15:0] addr;
        logic [15:0] data;
        logic [1:0]  cmd;
        int          bits;
        clk        = 1'b0;
        rst        = 1'b1;
        spi_clk    = 1'b0;
        spi_csn    = 1'b1;
        spi_mosi   = 1'b0;
        void'($urandom(32'h5135_89ac));
        for (int i = 0; i < reg_count; i++) begin
            ref_regs[i] = 16'h0000;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset values
        read_all();

        // Write then read back every register
        for (int a = 0; a < reg_count; a++) begin
            data = 16'($urandom());
            run_frame(cmd_wr, 16'(a), data, frame_bits);
            run_frame(cmd_rd, 16'(a), 16'h0000, frame_bits);
        end

        // Addresses past the bank
        for (int k = 0; k < 6; k++) begin
            addr = (k < 2) ? 16'(reg_count + k) : 16'($urandom_range(65535, reg_count));
            data = 16'($urandom());
            run_frame(cmd_wr, addr, data, frame_bits);
            run_frame(cmd_rd, addr, 16'h0000, frame_bits);
        end
        read_all();

        // Commands 0 and 3 are ignored
        for (int k = 0; k < 8; k++) begin
            cmd  = (k % 2 == 0) ? 2'd0 : 2'd3;
            addr = 16'($urandom_range(reg_count - 1, 0));
            data = 16'($urandom());
            run_frame(cmd, addr, data, frame_bits);
        end
        read_all();

        // Write frames cut short by chip select
        for (int k = 0; k < 4; k++) begin
            addr = 16'($urandom_range(reg_count - 1, 0));
            data = 16'($urandom());
            bits = $urandom_range(frame_bits - 1, data_first + 1);
            run_frame(cmd_wr, addr, data, bits);
            run_frame(cmd_rd, addr, 16'h0000, frame_bits);
            data = 16'($urandom());
            run_frame(cmd_wr, addr, data, frame_bits);
            run_frame(cmd_rd, addr, 16'h0000, frame_bits);
        end

        // Random traffic, a few addresses past the bank
        for (int k = 0; k < 200; k++) begin
            cmd  = ($urandom_range(1, 0) == 1) ? cmd_wr : cmd_rd;
            addr = 16'($urandom_range(reg_count + 3, 0));
            data = 16'($urandom());
            run_frame(cmd, addr, data, frame_bits);
        end

        wait_results_drained();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: spi_reg_top.sv
// SPI mode 0 register slave; clk at least 4x spi_clk, no burst, miso driven low when idle
`default_nettype none

module spi_reg_top #(
    parameter int DW        = spi_reg_pkg::data_w,
    parameter int AW        = spi_reg_pkg::addr_w,
    parameter int REG_COUNT = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic spi_clk,
    input  logic spi_csn,
    input  logic spi_mosi,
    output logic spi_miso
);

    logic                            header_flag;
    logic                            frame_flag;
    logic [$clog2(DW)-1:0]           tx_idx;
    logic                            tx_en;
    logic [spi_reg_pkg::frame_w-1:0] rx_word;
    logic                            read_active;
    logic [DW-1:0]                   rdata;
    logic                            rvalid;
    spi_reg_pkg::reg_req_t           req;

    // ========================================
    // SPI domain
    // ========================================
    spi_bit_counter #(.DW(DW), .AW(AW)) u_counter (
        .spi_clk     (spi_clk),
        .spi_csn     (spi_csn),
        .header_flag (header_flag),
        .frame_flag  (frame_flag),
        .tx_idx      (tx_idx),
        .tx_en       (tx_en)
    );

    spi_shifter #(.DW(DW)) u_shifter (
        .clk         (clk),
        .rst         (rst),
        .spi_clk     (spi_clk),
        .spi_csn     (spi_csn),
        .spi_mosi    (spi_mosi),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .tx_idx      (tx_idx),
        .tx_en       (tx_en),
        .read_active (read_active),
        .rx_word     (rx_word),
        .spi_miso    (spi_miso)
    );

    // ========================================
    // clk domain
    // ========================================
    spi_frame_ctrl #(.DW(DW), .AW(AW)) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .spi_csn     (spi_csn),
        .header_flag (header_flag),
        .frame_flag  (frame_flag),
        .rx_word     (rx_word),
        .req         (req),
        .read_active (read_active)
    );

    reg_bank #(.DW(DW), .AW(AW), .REG_COUNT(REG_COUNT)) u_bank (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

endmodule

`default_nettype wire

// File: reg_bank.sv
// REG_COUNT must be at least 2; out-of-range reads return zero and writes are dropped
`default_nettype none

module reg_bank #(
    parameter int DW        = 16,
    parameter int AW        = 16,
    parameter int REG_COUNT = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  spi_reg_pkg::reg_req_t req,
    output logic [DW-1:0]         rdata,
    output logic                  rvalid
);

    localparam int idx_w = $clog2(REG_COUNT);

    logic [DW-1:0]    regs [REG_COUNT];
    logic [AW-1:0]    addr;
    logic             in_range;
    logic [idx_w-1:0] idx;

    assign addr     = req.addr;
    assign in_range = (addr < AW'(REG_COUNT));
    assign idx      = addr[idx_w-1:0];

    // Write lands on the clock after wen, read answers one cycle after ren
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            rdata  <= '0;
            rvalid <= 1'b0;
        end else begin
            if (req.wen && in_range) begin
                regs[idx] <= req.wdata[DW-1:0];
            end
            rvalid <= req.ren;
            if (req.ren) begin
                rdata <= in_range ? regs[idx] : '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: spi_frame_ctrl.sv
// Needs clk at least 4x spi_clk so the synchronized flags are seen while rx_word is stable
`default_nettype none

module spi_frame_ctrl #(
    parameter int DW = 16,
    parameter int AW = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            spi_csn,
    input  logic                            header_flag,
    input  logic                            frame_flag,
    input  logic [spi_reg_pkg::frame_w-1:0] rx_word,
    output spi_reg_pkg::reg_req_t           req,
    output logic                            read_active
);

    typedef enum logic [1:0] {
        st_idle,
        st_write_wait,
        st_read_hold,
        st_skip
    } state_t;

    state_t state;

    // Bit 0 header, bit 1 frame, bit 2 chip select
    logic [2:0] sync_a;
    logic [2:0] sync_b;
    logic [2:0] sync_c;
    logic [2:0] rise;
    logic       hdr_rise;
    logic       frame_rise;
    logic       csn_rise;

    spi_reg_pkg::spi_header_t hdr;

    // ========================================
    // Synchronizers and edge detect
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_a <= '0;
            sync_b <= '0;
            sync_c <= '0;
        end else begin
            sync_a <= {spi_csn, frame_flag, header_flag};
            sync_b <= sync_a;
            sync_c <= sync_b;
        end
    end

    assign rise       = sync_b & ~sync_c;
    assign hdr_rise   = rise[0];
    assign frame_rise = rise[1];
    assign csn_rise   = rise[2];

    // Header sits in the low bits once bit 17 has been shifted in
    assign hdr = rx_word[spi_reg_pkg::cmd_w+AW-1:0];

    // ========================================
    // Frame FSM
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            req         <= '0;
            read_active <= 1'b0;
        end else begin
            // Strobes last one cycle
            req.wen <= 1'b0;
            req.ren <= 1'b0;

            case (state)
                st_idle: begin
                    if (hdr_rise) begin
                        req.addr <= hdr.addr;
                        if (hdr.cmd == spi_reg_pkg::cmd_read) begin
                            req.ren     <= 1'b1;
                            read_active <= 1'b1;
                            state       <= st_read_hold;
                        end else if (hdr.cmd == spi_reg_pkg::cmd_write) begin
                            state <= st_write_wait;
                        end else begin
                            state <= st_skip;
                        end
                    end
                end
                st_write_wait: begin
                    if (frame_rise) begin
                        req.wen   <= 1'b1;
                        req.wdata <= rx_word[DW-1:0];
                        state     <= st_idle;
                    end
                end
                st_read_hold: begin
                    if (frame_rise) begin
                        read_active <= 1'b0;
                        state       <= st_idle;
                    end
                end
                st_skip: begin
                    if (frame_rise) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            // Chip select rise wins over the state, but a completed frame
            // seen in the same cycle still keeps its write
            if (csn_rise) begin
                read_active <= 1'b0;
                state       <= st_idle;
            end
        end
    end

endmodule

`default_nettype wire

// File: spi_shifter.sv
// Transmit word must be loaded before the first data bit; miso is never tri-stated
`default_nettype none

module spi_shifter #(
    parameter int DW = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             spi_clk,
    input  logic                             spi_csn,
    input  logic                             spi_mosi,
    input  logic                             rvalid,
    input  logic [DW-1:0]                    rdata,
    input  logic [$clog2(DW)-1:0]            tx_idx,
    input  logic                             tx_en,
    input  logic                             read_active,
    output logic [spi_reg_pkg::frame_w-1:0]  rx_word,
    output logic                             spi_miso
);

    logic [DW-1:0] tx_word;

    // ========================================
    // Receive shift register
    // ========================================
    // Keeps its contents after chip select rises so the controller
    // can still capture the data field late in the window
    always_ff @(posedge spi_clk) begin
        if (!spi_csn) begin
            rx_word <= {rx_word[spi_reg_pkg::frame_w-2:0], spi_mosi};
        end
    end

    // ========================================
    // Transmit holding register, clk domain
    // ========================================
    // Loaded well inside the turnaround bit, then held steady
    // while the SPI side indexes it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_word <= '0;
        end else if (rvalid) begin
            tx_word <= rdata;
        end
    end

    // Index changes on falling spi_clk, host samples on the rising edge
    always_comb begin
        if (tx_en && read_active) begin
            spi_miso = tx_word[tx_idx];
        end else begin
            spi_miso = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: spi_bit_counter.sv
// SPI mode 0 only; counters are cleared by spi_csn high, one frame per chip-select window
`default_nettype none

module spi_bit_counter #(
    parameter int DW = 16,
    parameter int AW = 16
) (
    input  logic                  spi_clk,
    input  logic                  spi_csn,
    output logic                  header_flag,
    output logic                  frame_flag,
    output logic [$clog2(DW)-1:0] tx_idx,
    output logic                  tx_en
);

    // Bit positions within the frame
    localparam int hdr_last   = spi_reg_pkg::cmd_w + AW - 1;
    localparam int frame_last = spi_reg_pkg::cmd_w + AW + DW;
    localparam int data_first = hdr_last + 2;
    localparam int cnt_w      = $clog2(frame_last + 1);

    logic [cnt_w-1:0] rx_cnt;

    // ========================================
    // Receive side, rising spi_clk
    // ========================================
    always_ff @(posedge spi_clk or posedge spi_csn) begin
        if (spi_csn) begin
            rx_cnt <= '0;
        end else if (rx_cnt == cnt_w'(frame_last)) begin
            rx_cnt <= '0;
        end else begin
            rx_cnt <= rx_cnt + 1'b1;
        end
    end

    // Flags stay high for one full spi_clk period
    always_ff @(posedge spi_clk or posedge spi_csn) begin
        if (spi_csn) begin
            header_flag <= 1'b0;
            frame_flag  <= 1'b0;
        end else begin
            header_flag <= (rx_cnt == cnt_w'(hdr_last));
            frame_flag  <= (rx_cnt == cnt_w'(frame_last));
        end
    end

    // ========================================
    // Transmit side, falling spi_clk
    // ========================================
    // Turnaround bit already sampled when rx_cnt reads data_first
    always_ff @(negedge spi_clk or posedge spi_csn) begin
        if (spi_csn) begin
            tx_idx <= '0;
            tx_en  <= 1'b0;
        end else if (rx_cnt == cnt_w'(data_first)) begin
            tx_idx <= $clog2(DW)'(DW - 1);
            tx_en  <= 1'b1;
        end else if (tx_en) begin
            tx_idx <= tx_idx - 1'b1;
            tx_en  <= (tx_idx != '0);
        end
    end

endmodule

`default_nettype wire

// File: spi_reg_pkg.sv
// Field widths here are fixed at 16 bits; DW and AW in the RTL must match data_w and addr_w
`default_nettype none

package spi_reg_pkg;

    // ========================================
    // Frame layout, MSB first
    // ========================================
    localparam int cmd_w   = 2;
    localparam int addr_w  = 16;
    localparam int data_w  = 16;
    // Command, address, one turnaround bit, data
    localparam int frame_w = cmd_w + addr_w + 1 + data_w;

    typedef logic [cmd_w-1:0] spi_cmd_t;

    localparam spi_cmd_t cmd_write = 2'd2;
    localparam spi_cmd_t cmd_read  = 2'd1;

    // ========================================
    // Shared structs
    // ========================================
    // Decoded frame header
    typedef struct packed {
        spi_cmd_t          cmd;
        logic [addr_w-1:0] addr;
    } spi_header_t;

    // Controller to register bank
    typedef struct packed {
        logic              wen;
        logic              ren;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } reg_req_t;

endpackage

`default_nettype wire
